//--- common/decodePkg.sv
package decodePkg;

    // Word widths fixed by the ISA
    localparam int INSTR_W  = 33;
    localparam int DATA_W   = 18;
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = $clog2(NUM_REGS);

    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [DATA_W-1:0]  pcAddr_t;   // Full width PC
    typedef logic [REG_AW-1:0]  regAddr_t;
    typedef logic [2:0]         aluCtrl_t;
    typedef logic [1:0]         rgb_t;      // Colour select for the display device

    // Instruction word layout
    localparam int IMM_BIT = 32;            // Immediate operand flag
    localparam int TYPE_HI = 31;
    localparam int TYPE_LO = 30;
    localparam int OP_HI   = 29;
    localparam int OP_LO   = 28;
    localparam int RS1_HI  = 27;
    localparam int RS1_LO  = 23;
    localparam int RS2_HI  = 22;
    localparam int RS2_LO  = 18;
    localparam int RD_HI   = 4;
    localparam int RD_LO   = 0;

    // Immediate fields share the top end of the low 18 bits
    localparam int IMM_HI     = 17;
    localparam int IMM_LO     = 0;
    localparam int IMM_S_LO   = 5;          // Short immediate for memory and branch
    localparam int IMM_S_W    = IMM_HI - IMM_S_LO + 1;

    // ALU operation codes used by decode
    localparam aluCtrl_t ALU_ADD = 3'b000;
    localparam aluCtrl_t ALU_SUB = 3'b001;

    typedef enum logic [1:0] {
        IMM_ALU    = 2'b00,                 // Bits 17..0 as they are
        IMM_MEM    = 2'b01,                 // Bits 17..5 sign extended
        IMM_BRANCH = 2'b10,                 // Same, then shifted left by two
        IMM_NONE   = 2'b11
    } immSrc_t;

    typedef enum logic [1:0] {
        TYPE_ALU    = 2'b00,
        TYPE_MEM    = 2'b01,
        TYPE_BRANCH = 2'b10,
        TYPE_COLOR  = 2'b11
    } instrType_t;

    // Memory instructions use op bit 0 to pick load or store
    localparam int OP_STORE_BIT = 0;

endpackage

//--- common/decodeCtrlIf.sv
`timescale 1ns/1ps

interface decodeCtrlIf;
    import decodePkg::*;

    logic     regWrite;
    logic     aluSrc;     // Second ALU operand from immediate
    logic     memWrite;
    logic     resultSrc;  // Result from memory instead of ALU
    logic     branch;
    aluCtrl_t aluControl;
    immSrc_t  immSrc;
    rgb_t     rgb;

    // Driven by the control unit
    modport ctrl (
        output regWrite, aluSrc, memWrite, resultSrc, branch,
        output aluControl, immSrc, rgb
    );

    // Sampled by the decode/execute register
    modport stage (
        input regWrite, aluSrc, memWrite, resultSrc, branch,
        input aluControl, rgb
    );

    // Only the immediate select is needed by the extender
    modport ext (
        input immSrc
    );

endinterface

//--- source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  decodePkg::instrType_t instrType,
    input  logic [1:0]            op,
    input  logic                  immBit,
    decodeCtrlIf.ctrl             ctrl
);
    import decodePkg::*;

    logic isStore;

    assign isStore = op[OP_STORE_BIT];

    always_comb begin
        // Anything a type does not set stays inactive
        ctrl.regWrite   = 1'b0;
        ctrl.aluSrc     = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.resultSrc  = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.aluControl = ALU_ADD;
        ctrl.immSrc     = IMM_NONE;
        ctrl.rgb        = '0;

        case (instrType)
            TYPE_ALU: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrc     = immBit;        // Register or immediate operand
                ctrl.aluControl = {1'b0, op};
                ctrl.immSrc     = IMM_ALU;
            end

            TYPE_MEM: begin
                ctrl.aluSrc     = 1'b1;          // Address is base plus offset
                ctrl.immSrc     = IMM_MEM;
                if (isStore) begin
                    ctrl.memWrite = 1'b1;
                end else begin
                    ctrl.regWrite   = 1'b1;
                    ctrl.resultSrc  = 1'b1;      // Load data goes to the register
                    ctrl.aluControl = ALU_ADD;
                end
            end

            TYPE_BRANCH: begin
                ctrl.branch     = 1'b1;
                ctrl.aluControl = ALU_SUB;       // Compare by subtraction
                ctrl.immSrc     = IMM_BRANCH;
            end

            TYPE_COLOR: begin
                ctrl.rgb    = op;
                ctrl.immSrc = IMM_NONE;
            end

            default: begin
                ctrl.immSrc = IMM_NONE;
            end
        endcase
    end

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic               clk,
    input  logic               rst,
    input  logic               writeEn,
    input  decodePkg::regAddr_t writeAddr,
    input  decodePkg::data_t    writeData,
    input  decodePkg::regAddr_t readAddr1,
    input  decodePkg::regAddr_t readAddr2,
    output decodePkg::data_t    readData1,
    output decodePkg::data_t    readData2
);
    import decodePkg::*;

    data_t regs [NUM_REGS];

    // Zero register, then same-cycle write bypass, then stored value
    function automatic data_t readPort(regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (writeEn && (addr == writeAddr)) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;   // Register zero never changes
        end
    end

    always_comb begin
        readData1 = readPort(readAddr1);
        readData2 = readPort(readAddr2);
    end

endmodule

//--- source/immExtend.sv
`timescale 1ns/1ps

module immExtend (
    input  decodePkg::instr_t instr,
    decodeCtrlIf.ext          ext,
    output decodePkg::data_t  immExt
);
    import decodePkg::*;

    logic [IMM_S_W-1:0] shortImm;
    logic               signBit;

    assign shortImm = instr[IMM_HI:IMM_S_LO];
    assign signBit  = instr[IMM_HI];

    always_comb begin
        case (ext.immSrc)
            IMM_ALU: begin
                immExt = instr[IMM_HI:IMM_LO];   // Full 18 bit field
            end

            IMM_MEM: begin
                immExt = {{(DATA_W - IMM_S_W){signBit}}, shortImm};
            end

            IMM_BRANCH: begin
                // Word offset turned into a byte offset
                immExt = {{(DATA_W - IMM_S_W - 2){signBit}}, shortImm, 2'b00};
            end

            IMM_NONE: begin
                immExt = '0;
            end

            default: begin
                immExt = '0;
            end
        endcase
    end

endmodule

//--- source/decodeRegister.sv
`timescale 1ns/1ps

module decodeRegister (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    decodeCtrlIf.stage          ctrl,
    input  decodePkg::instr_t   instr,
    input  decodePkg::data_t    readData1,
    input  decodePkg::data_t    readData2,
    input  decodePkg::data_t    immExt,
    input  decodePkg::pcAddr_t  pc,
    input  decodePkg::pcAddr_t  pcPlus4,
    output logic                regWriteE,
    output logic                aluSrcE,
    output logic                memWriteE,
    output logic                resultSrcE,
    output logic                branchE,
    output logic                flushE,
    output decodePkg::aluCtrl_t aluControlE,
    output decodePkg::data_t    rd1E,
    output decodePkg::data_t    rd2E,
    output decodePkg::data_t    immExtE,
    output decodePkg::regAddr_t rs1E,
    output decodePkg::regAddr_t rs2E,
    output decodePkg::regAddr_t rdE,
    output decodePkg::pcAddr_t  pcE,
    output decodePkg::pcAddr_t  pcPlus4E,
    output decodePkg::rgb_t     rgbE
);
    import decodePkg::*;

    instrType_t instrType;
    regAddr_t   destReg;

    assign instrType = instrType_t'(instr[TYPE_HI:TYPE_LO]);

    // Memory ops name their data register in the rs1 field
    always_comb begin
        if (instrType == TYPE_MEM) begin
            destReg = instr[RS1_HI:RS1_LO];
        end else if (instr[IMM_BIT]) begin
            destReg = instr[RS2_HI:RS2_LO];  // Immediate form reuses rs2 slot
        end else begin
            destReg = instr[RD_HI:RD_LO];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteE   <= 1'b0;
            aluSrcE     <= 1'b0;
            memWriteE   <= 1'b0;
            resultSrcE  <= 1'b0;
            branchE     <= 1'b0;
            flushE      <= 1'b0;
            aluControlE <= '0;
            rd1E        <= '0;
            rd2E        <= '0;
            immExtE     <= '0;
            rs1E        <= '0;
            rs2E        <= '0;
            rdE         <= '0;
            pcE         <= '0;
            pcPlus4E    <= '0;
            rgbE        <= '0;
        end else begin
            flushE <= stall;                  // Tracks stall every cycle
            if (!stall) begin
                regWriteE   <= ctrl.regWrite;
                aluSrcE     <= ctrl.aluSrc;
                memWriteE   <= ctrl.memWrite;
                resultSrcE  <= ctrl.resultSrc;
                branchE     <= ctrl.branch;
                aluControlE <= ctrl.aluControl;
                rgbE        <= ctrl.rgb;
                rd1E        <= readData1;
                rd2E        <= readData2;
                immExtE     <= immExt;
                rs1E        <= instr[RS1_HI:RS1_LO];
                rs2E        <= instr[RS2_HI:RS2_LO];
                rdE         <= destReg;
                pcE         <= pc;
                pcPlus4E    <= pcPlus4;
            end
        end
    end

endmodule

//--- source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                regWriteW,
    input  logic                stallD,
    input  decodePkg::regAddr_t rdW,
    input  decodePkg::instr_t   instrD,
    input  decodePkg::pcAddr_t  pcD,
    input  decodePkg::pcAddr_t  pcPlus4D,
    input  decodePkg::data_t    resultW,
    output logic                regWriteE,
    output logic                aluSrcE,
    output logic                memWriteE,
    output logic                resultSrcE,
    output logic                branchE,
    output logic                flushE,
    output decodePkg::aluCtrl_t aluControlE,
    output decodePkg::data_t    rd1E,
    output decodePkg::data_t    rd2E,
    output decodePkg::data_t    immExtE,
    output decodePkg::regAddr_t rs1E,
    output decodePkg::regAddr_t rs2E,
    output decodePkg::regAddr_t rdE,
    output decodePkg::pcAddr_t  pcE,
    output decodePkg::pcAddr_t  pcPlus4E,
    output decodePkg::rgb_t     rgbE
);
    import decodePkg::*;

    data_t rd1D;
    data_t rd2D;
    data_t immExtD;

    decodeCtrlIf ctrlBus ();   // Control bundle from decode to the stage register

    controlUnit control_i (
        .instrType (instrType_t'(instrD[TYPE_HI:TYPE_LO])),
        .op        (instrD[OP_HI:OP_LO]),
        .immBit    (instrD[IMM_BIT]),
        .ctrl      (ctrlBus.ctrl)
    );

    // Writeback port comes straight from the later stage
    registerFile regFile_i (
        .clk       (clk),
        .rst       (rst),
        .writeEn   (regWriteW),
        .writeAddr (rdW),
        .writeData (resultW),
        .readAddr1 (instrD[RS1_HI:RS1_LO]),
        .readAddr2 (instrD[RS2_HI:RS2_LO]),
        .readData1 (rd1D),
        .readData2 (rd2D)
    );

    immExtend immExt_i (
        .instr  (instrD),
        .ext    (ctrlBus.ext),
        .immExt (immExtD)
    );

    decodeRegister decodeReg_i (
        .clk(clk),             .rst(rst),               .stall(stallD),
        .ctrl(ctrlBus.stage),  .instr(instrD),
        .readData1(rd1D),      .readData2(rd2D),        .immExt(immExtD),
        .pc(pcD),              .pcPlus4(pcPlus4D),
        .regWriteE(regWriteE), .aluSrcE(aluSrcE),       .memWriteE(memWriteE),
        .resultSrcE(resultSrcE), .branchE(branchE),     .flushE(flushE),
        .aluControlE(aluControlE),
        .rd1E(rd1E),           .rd2E(rd2E),             .immExtE(immExtE),
        .rs1E(rs1E),           .rs2E(rs2E),             .rdE(rdE),
        .pcE(pcE),             .pcPlus4E(pcPlus4E),     .rgbE(rgbE)
    );

endmodule

//--- dv/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Shadow copy of the architectural registers
data_t shadowRegs [32];

// Packed as {regWrite, aluSrc, memWrite, resultSrc, branch, aluControl, rgb}
function automatic logic [9:0] modelCtrl(instr_t instr);
    logic [1:0] op;
    op = instr[29:28];
    case (instr[31:30])
        2'b00:   return {1'b1, instr[32], 3'b000, 1'b0, op, 2'b00};
        2'b01: begin
            if (op[0]) begin
                return {5'b01100, 3'b000, 2'b00};   // Store
            end
            return {5'b11010, 3'b000, 2'b00};       // Load
        end
        2'b10:   return {5'b00001, 3'b001, 2'b00};
        default: return {5'b00000, 3'b000, op};     // Colour
    endcase
endfunction

function automatic data_t modelImm(instr_t instr);
    case (instr[31:30])
        2'b00:   return instr[17:0];
        2'b01:   return {{5{instr[17]}}, instr[17:5]};
        2'b10:   return {{3{instr[17]}}, instr[17:5], 2'b00};
        default: return 18'd0;
    endcase
endfunction

function automatic regAddr_t modelDest(instr_t instr);
    if (instr[31:30] == 2'b01) begin
        return instr[27:23];
    end else if (instr[32]) begin
        return instr[22:18];
    end
    return instr[4:0];
endfunction

task automatic shadowClear();
    for (int i = 0; i < 32; i++) begin
        shadowRegs[i] = '0;
    end
endtask

task automatic shadowWrite(input logic en, input regAddr_t addr, input data_t data);
    if (en && addr != 5'd0) begin
        shadowRegs[addr] = data;
    end
endtask

// Register read as seen during a cycle that also carries a writeback
function automatic data_t shadowRead(regAddr_t addr, logic en, regAddr_t wAddr, data_t wData);
    if (addr == 5'd0) begin
        return 18'd0;
    end else if (en && addr == wAddr) begin
        return wData;
    end
    return shadowRegs[addr];
endfunction

`endif

//--- dv/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb;
    import decodePkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int DECODE_COUNT = 200;
    localparam int WB_COUNT     = 40;
    localparam int WT_COUNT     = 20;
    localparam int STALL_COUNT  = 30;
    localparam int MAX_STALL    = 4;
    localparam int TOTAL_CYCLES = RESET_CYCLES + DECODE_COUNT + 2 * WB_COUNT + WT_COUNT
                                + STALL_COUNT * (MAX_STALL + 1) + 4;
    localparam instr_t NOP_INSTR = 33'h0_C000_0000;   // Colour op 0 that decodes to all zero

    typedef struct packed {
        logic        regWrite;
        logic        aluSrc;
        logic        memWrite;
        logic        resultSrc;
        logic        branch;
        aluCtrl_t    aluControl;
        logic [1:0]  rgb;
        logic        flush;
        data_t       rd1;
        data_t       rd2;
        data_t       imm;
        regAddr_t    rs1;
        regAddr_t    rs2;
        regAddr_t    rd;
        pcAddr_t     pc;
        pcAddr_t     pcPlus4;
    } execOut_t;

    logic clk, rst, regWriteW, stallD;
    regAddr_t rdW;
    instr_t instrD;
    pcAddr_t pcD, pcPlus4D;
    data_t resultW;
    logic regWriteE, aluSrcE, memWriteE, resultSrcE, branchE, flushE;
    aluCtrl_t aluControlE;
    data_t rd1E, rd2E, immExtE;
    regAddr_t rs1E, rs2E, rdE;
    pcAddr_t pcE, pcPlus4E;
    rgb_t rgbE;

    integer seed;
    int checks;
    int errors;
    string testName;
    execOut_t pending;    // What the next unstalled edge should capture
    execOut_t expected;

    `include "decodeModel.svh"

    decodeStage dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic instr_t randInstr();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[32:0];
    endfunction

    task automatic driveCycle(input instr_t instr, input logic stall, input logic wen,
                              input regAddr_t wAddr, input data_t wData);
        pcAddr_t pcVal;
        @(posedge clk);
        #2;
        pcVal     = 18'($random(seed));
        instrD    = instr;
        pcD       = pcVal;
        pcPlus4D  = pcVal + 18'd4;
        stallD    = stall;
        regWriteW = wen;
        rdW       = wAddr;
        resultW   = wData;
        {pending.regWrite, pending.aluSrc, pending.memWrite, pending.resultSrc,
         pending.branch, pending.aluControl, pending.rgb} = modelCtrl(instr);
        pending.flush   = 1'b0;
        pending.rd1     = shadowRead(instr[27:23], wen, wAddr, wData);
        pending.rd2     = shadowRead(instr[22:18], wen, wAddr, wData);
        pending.imm     = modelImm(instr);
        pending.rs1     = instr[27:23];
        pending.rs2     = instr[22:18];
        pending.rd      = modelDest(instr);
        pending.pc      = pcVal;
        pending.pcPlus4 = pcVal + 18'd4;
        shadowWrite(wen, wAddr, wData);   // Lands at the coming edge
    endtask

    task automatic checkField(input string field, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checks++;
        assert (actVal == expVal) else begin
            errors++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", testName, field, expVal, actVal);
        end
    endtask

    // Mirror of the stage register updated just after each edge
    always @(posedge clk) begin
        #1;
        if (!rst) begin
            expected = '0;
        end else begin
            if (!stallD) begin
                expected = pending;
            end
            expected.flush = stallD;
        end
    end

    always @(posedge clk) begin
        #(CLK_PERIOD - 1);   // Outputs have settled before the next edge
        checkField("regWriteE", 32'(expected.regWrite), 32'(regWriteE));
        checkField("aluSrcE", 32'(expected.aluSrc), 32'(aluSrcE));
        checkField("memWriteE", 32'(expected.memWrite), 32'(memWriteE));
        checkField("resultSrcE", 32'(expected.resultSrc), 32'(resultSrcE));
        checkField("branchE", 32'(expected.branch), 32'(branchE));
        checkField("flushE", 32'(expected.flush), 32'(flushE));
        checkField("aluControlE", 32'(expected.aluControl), 32'(aluControlE));
        checkField("rgbE", 32'(expected.rgb), 32'(rgbE));
        checkField("rd1E", 32'(expected.rd1), 32'(rd1E));
        checkField("rd2E", 32'(expected.rd2), 32'(rd2E));
        checkField("immExtE", 32'(expected.imm), 32'(immExtE));
        checkField("rs1E", 32'(expected.rs1), 32'(rs1E));
        checkField("rs2E", 32'(expected.rs2), 32'(rs2E));
        checkField("rdE", 32'(expected.rd), 32'(rdE));
        checkField("pcE", 32'(expected.pc), 32'(pcE));
        checkField("pcPlus4E", 32'(expected.pcPlus4), 32'(pcPlus4E));
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("Timeout: test sequence still running after %0d cycles", TOTAL_CYCLES * 2);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        instr_t instr;
        regAddr_t addr;
        data_t data;
        int len;
        seed      = 32'h8cc3_76b1;
        checks    = 0;
        errors    = 0;
        clk       = 1'b0;
        rst       = 1'b0;
        regWriteW = 1'b0;
        stallD    = 1'b0;
        rdW       = '0;
        instrD    = NOP_INSTR;
        pcD       = '0;
        pcPlus4D  = '0;
        resultW   = '0;
        pending   = '0;
        expected  = '0;
        shadowClear();

        testName = "reset";
        for (int i = 0; i < RESET_CYCLES; i++) begin
            // Busy inputs that the reset has to keep off the outputs
            driveCycle(randInstr(), i[0], 1'b0, 5'd0, 18'd0);
        end
        rst = 1'b1;

        testName = "decode";
        for (int i = 0; i < DECODE_COUNT; i++) begin
            instr        = randInstr();
            instr[31:30] = i[1:0];   // Every type, both imm forms, loads and stores
            instr[32]    = i[2];
            instr[28]    = i[3];
            driveCycle(instr, 1'b0, 1'b0, 5'd0, 18'd0);
        end

        testName = "writeback";
        for (int i = 0; i < WB_COUNT; i++) begin
            addr = (i % 8 == 0) ? 5'd0 : 5'($random(seed));
            data = 18'($random(seed));
            instr        = randInstr();
            instr[22:18] = addr;     // Same-cycle read of the register being written
            driveCycle(instr, 1'b0, 1'b1, addr, data);
            instr        = randInstr();
            instr[27:23] = addr;
            driveCycle(instr, 1'b0, 1'b0, 5'd0, 18'd0);
        end

        testName = "writethrough";
        for (int i = 0; i < WT_COUNT; i++) begin
            addr  = 5'($random(seed)) | 5'd1;
            data  = 18'($random(seed));
            instr = randInstr();
            if (i[0]) begin
                instr[27:23] = addr;
            end else begin
                instr[22:18] = addr;
            end
            driveCycle(instr, 1'b0, 1'b1, addr, data);
        end

        testName = "stall";
        for (int i = 0; i < STALL_COUNT; i++) begin
            len = 1 + ({$random(seed)} % MAX_STALL);
            for (int j = 0; j < len; j++) begin
                // Writes keep going under stall
                driveCycle(randInstr(), 1'b1, i[0], 5'($random(seed)), 18'($random(seed)));
            end
            driveCycle(randInstr(), 1'b0, 1'b0, 5'd0, 18'd0);
        end

        driveCycle(NOP_INSTR, 1'b0, 1'b0, 5'd0, 18'd0);
        @(posedge clk);
        @(posedge clk);
        #5;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+dv
common/decodePkg.sv
common/decodeCtrlIf.sv
source/controlUnit.sv
source/registerFile.sv
source/immExtend.sv
source/decodeRegister.sv
source/decodeStage.sv
dv/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module decodeStageTb -f tb.f -o decodeStageSim \
    && ./obj_dir/decodeStageSim | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "decode stage run: ok" \
    || { echo "decode stage run: failed"; exit 1; }
